/* build.f */
src/hps_pkg.sv
src/conf_str_rom.sv
src/hps_cmd_frame.sv
src/core_io_regs.sv
src/file_loader.sv
src/hps_io_top.sv
bench/hps_io_sva.sv
bench/tb_hps_io.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the bridge testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_hps_io \
	-f build.f -Mdir obj_dir -o sim_hps_io > build.log 2>&1 &&
	./obj_dir/sim_hps_io > sim.log 2>&1 ||
	echo "build or simulation returned an error"

grep -qxF '** PASS **' sim.log && echo "simulation passed" && exit 0 ||
	{ echo "simulation failed"; exit 1; }

/* bench/tb_hps_io.sv */
`timescale 1ns/1ns
/*
 * testbench for the host I/O bridge
 * directed core and file channel frames with checked replies and outputs
 */
module tb_hps_io;

	logic                  clk_sys = 1'b0;
	logic                  rst;
	logic                  io_strobe;
	logic                  io_enable;
	logic                  fp_enable;
	hps_pkg::io_word_t     io_din;
	hps_pkg::status_t      status_in;
	logic                  status_set;
	logic                  ioctl_wait;
	hps_pkg::io_word_t     io_dout;
	logic                  host_wait;
	logic [1:0]            buttons;
	logic                  forced_scandoubler;
	logic                  direct_video;
	hps_pkg::joy_t         joystick_0;
	hps_pkg::joy_t         joystick_1;
	hps_pkg::status_t      status;
	logic                  ioctl_download;
	hps_pkg::ioctl_index_t ioctl_index;
	logic                  ioctl_wr;
	hps_pkg::ioctl_addr_t  ioctl_addr;
	hps_pkg::ioctl_data_t  ioctl_dout;

	int                    n_bytes = 16;
	bit                    verdict_done = 1'b0;
	int                    wr_count = 0;
	logic [15:0]           lfsr_state = 16'd33379;

	// words of the next frame and the reply expected for each
	hps_pkg::io_word_t     tx_words[$];
	hps_pkg::io_word_t     exp_replies[$];
	hps_pkg::ioctl_data_t  exp_bytes[$];

	hps_io_top i_hps_io_top (.*);

	always #2 clk_sys = ~clk_sys;

	////////////////////////////////////////////////////////////////////////////
	// random data, x^16 + x^14 + x^13 + x^11 + 1
	////////////////////////////////////////////////////////////////////////////

	function automatic logic take_bit();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic hps_pkg::io_word_t rand_word();
		hps_pkg::io_word_t w;
		w = '0;
		for (int i = 0; i < 16; i++) begin
			w = {w[14:0], take_bit()};
		end
		return w;
	endfunction

	function automatic hps_pkg::status_t rand_status();
		hps_pkg::status_t s;
		s = '0;
		for (int k = 0; k < 4; k++) begin
			s = {s[47:0], rand_word()};
		end
		return s;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// error reporting and compares
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string msg);
		verdict_done = 1'b1;
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input string what, input hps_pkg::io_word_t got,
		input hps_pkg::io_word_t exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL %0t %s: got %h, expected %h", $time, what, got, exp));
		end
	endtask

	task automatic check_joy(input string what, input hps_pkg::joy_t got,
		input hps_pkg::joy_t exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL %0t %s: got %h, expected %h", $time, what, got, exp));
		end
	endtask

	task automatic check_status(input string what, input hps_pkg::status_t got,
		input hps_pkg::status_t exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL %0t %s: got %h, expected %h", $time, what, got, exp));
		end
	endtask

	task automatic check_addr(input string what, input hps_pkg::ioctl_addr_t got,
		input hps_pkg::ioctl_addr_t exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL %0t %s: got %h, expected %h", $time, what, got, exp));
		end
	endtask

	task automatic check_data(input string what, input hps_pkg::ioctl_data_t got,
		input hps_pkg::ioctl_data_t exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL %0t %s: got %h, expected %h", $time, what, got, exp));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// host bus
	////////////////////////////////////////////////////////////////////////////

	// called on a rising edge, returns on the edge where the next strobe may go
	task automatic send_frame_word(input hps_pkg::io_word_t w, output hps_pkg::io_word_t reply);
		io_strobe <= 1'b1;
		io_din    <= w;
		@(posedge clk_sys);
		io_strobe <= 1'b0;
		@(posedge clk_sys);
		// reply is settled here and holds until the next strobe
		@(negedge clk_sys);
		reply = io_dout;
		@(posedge clk_sys);
	endtask

	task automatic open_frame(input bit file_chan);
		if (file_chan) begin
			fp_enable <= 1'b1;
		end else begin
			io_enable <= 1'b1;
		end
		@(posedge clk_sys);
	endtask

	task automatic close_frame();
		io_enable <= 1'b0;
		fp_enable <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic add_word(input hps_pkg::io_word_t w, input hps_pkg::io_word_t exp);
		tx_words.push_back(w);
		exp_replies.push_back(exp);
	endtask

	// file frames keep io_dout at zero, so every reply is checked
	task automatic send_frame(input bit file_chan);
		hps_pkg::io_word_t reply;
		open_frame(file_chan);
		foreach (tx_words[i]) begin
			send_frame_word(tx_words[i], reply);
			check_word($sformatf("reply to word %0d", i), reply, exp_replies[i]);
		end
		close_frame();
		tx_words.delete();
		exp_replies.delete();
	endtask

	task automatic set_download(input bit on);
		hps_pkg::io_word_t arg;
		arg = rand_word();
		arg[7:0] = on ? (arg[7:0] | 8'h01) : 8'h00;
		add_word(hps_pkg::FIO_FILE_TX, '0);
		add_word(arg, '0);
		send_frame(1'b1);
		check_word("download flag", {15'd0, ioctl_download}, {15'd0, on});
	endtask

	// every write pulse must match the next expected byte
	always @(negedge clk_sys) begin
		if (!rst && ioctl_wr) begin
			if (exp_bytes.size() == 0) begin
				abort_run("ioctl_wr pulsed although no byte was sent on an open file channel");
			end else begin
				check_addr("download address", ioctl_addr, hps_pkg::ioctl_addr_t'(wr_count));
				check_data("download byte", ioctl_dout, exp_bytes.pop_front());
				wr_count++;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic config_and_joysticks();
		hps_pkg::io_word_t cfg_w;
		hps_pkg::io_word_t lo;
		hps_pkg::io_word_t hi;
		cfg_w = rand_word();
		add_word(hps_pkg::CMD_CFG, '0);
		add_word(cfg_w, '0);
		send_frame(1'b0);
		check_word("config outputs", {12'h000, direct_video, forced_scandoubler, buttons},
			{12'h000, cfg_w[10], cfg_w[4], cfg_w[1:0]});
		for (int j = 0; j < 2; j++) begin
			lo = rand_word();
			hi = rand_word();
			add_word((j == 0) ? hps_pkg::CMD_JOY0 : hps_pkg::CMD_JOY1, '0);
			add_word(lo, '0);
			add_word(hi, '0);
			send_frame(1'b0);
			check_joy($sformatf("joystick %0d", j), (j == 0) ? joystick_0 : joystick_1, {hi, lo});
		end
	endtask

	task automatic status_write();
		hps_pkg::status_t v;
		v = rand_status();
		add_word(hps_pkg::CMD_STATUS, '0);
		for (int k = 0; k < 4; k++) begin
			add_word(v[16*k +: 16], '0);
		end
		send_frame(1'b0);
		check_status("status word", status, v);
	endtask

	task automatic status_request();
		hps_pkg::status_t first;
		hps_pkg::status_t second;
		first  = rand_status();
		second = rand_status();
		status_in  <= first;
		status_set <= 1'b1;
		@(posedge clk_sys);
		status_set <= 1'b0;
		repeat (2) @(posedge clk_sys);
		// second request stays high while the input keeps moving
		status_in  <= second;
		status_set <= 1'b1;
		@(posedge clk_sys);
		status_in <= rand_status();
		repeat (6) @(posedge clk_sys);
		status_set <= 1'b0;
		@(posedge clk_sys);
		add_word(hps_pkg::CMD_STATUS_REQ, {8'h00, hps_pkg::STATUS_REQ_TAG, 4'd2});
		for (int k = 0; k < 4; k++) begin
			add_word(rand_word(), second[16*k +: 16]);
		end
		send_frame(1'b0);
	endtask

	// first character sits in the top byte of the packed string
	task automatic config_string_read();
		add_word(hps_pkg::CMD_CONF_STR, '0);
		for (int k = 1; k <= hps_pkg::CONF_LEN + 2; k++) begin
			if (k <= hps_pkg::CONF_LEN) begin
				add_word(rand_word(), {8'h00, hps_pkg::CONF_STR[(hps_pkg::CONF_LEN - k) * 8 +: 8]});
			end else begin
				add_word(rand_word(), '0);
			end
		end
		send_frame(1'b0);
	endtask

	task automatic file_download();
		hps_pkg::ioctl_index_t idx;
		hps_pkg::io_word_t     w;
		idx = rand_word();
		add_word(hps_pkg::FIO_FILE_INDEX, '0);
		add_word(idx, '0);
		send_frame(1'b1);
		check_word("file index", ioctl_index, idx);
		set_download(1'b1);
		wr_count = 0;
		add_word(hps_pkg::FIO_FILE_TX_DAT, '0);
		for (int k = 0; k < n_bytes; k++) begin
			w = rand_word();
			exp_bytes.push_back(w[7:0]);
			add_word(w, '0);
		end
		send_frame(1'b1);
		check_addr("bytes written", hps_pkg::ioctl_addr_t'(wr_count),
			hps_pkg::ioctl_addr_t'(n_bytes));
		set_download(1'b0);
		check_addr("byte count after stop", ioctl_addr, hps_pkg::ioctl_addr_t'(n_bytes));
	endtask

	task automatic closed_channel_ignored();
		hps_pkg::io_word_t lo;
		hps_pkg::io_word_t hi;
		hps_pkg::io_word_t reply;
		int                writes_before;
		lo = rand_word();
		hi = rand_word();
		add_word(hps_pkg::CMD_JOY0, '0);
		add_word(lo, '0);
		add_word(hi, '0);
		send_frame(1'b0);
		check_joy("joystick 0 after download", joystick_0, {hi, lo});
		// download running, only the closed channel keeps the byte out
		set_download(1'b1);
		writes_before = wr_count;
		send_frame_word(hps_pkg::FIO_FILE_TX_DAT, reply);
		check_word("reply outside a frame", reply, '0);
		send_frame_word(rand_word(), reply);
		check_word("reply outside a frame", reply, '0);
		repeat (3) @(posedge clk_sys);
		check_addr("writes with channel closed", hps_pkg::ioctl_addr_t'(wr_count),
			hps_pkg::ioctl_addr_t'(writes_before));
		check_joy("joystick 0 with channel closed", joystick_0, {hi, lo});
		set_download(1'b0);
		check_addr("byte count of empty download", ioctl_addr, '0);
	endtask

	// host wait follows the core busy input within the cycle
	task automatic wait_passthrough();
		for (int k = 0; k < 2; k++) begin
			ioctl_wait <= (k == 0);
			@(negedge clk_sys);
			check_word("host wait", {15'd0, host_wait}, {15'd0, k == 0});
			@(posedge clk_sys);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// run control
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int bus_words;
		bus_words = 2 + 3 + 3 + 5 + 5 + (hps_pkg::CONF_LEN + 3) + 2 + 2 + (n_bytes + 1) + 2 +
			3 + 2 + 2 + 2;
		repeat (40 * bus_words + 500) @(posedge clk_sys);
		verdict_done = 1'b1;
		$display("timeout: the tests did not finish within %0d clock cycles",
			40 * bus_words + 500);
		$display("** FAIL **");
		$fatal(1, "watchdog expired");
	end

	initial begin
		rst        = 1'b1;
		io_strobe  = 1'b0;
		io_enable  = 1'b0;
		fp_enable  = 1'b0;
		io_din     = '0;
		status_in  = '0;
		status_set = 1'b0;
		ioctl_wait = 1'b0;
		repeat (8) @(posedge clk_sys);
		rst <= 1'b0;
		@(posedge clk_sys);
		check_word("reply after reset", io_dout, '0);
		check_word("download flags after reset", {14'd0, ioctl_download, ioctl_wr}, '0);

		config_and_joysticks();
		status_write();
		status_request();
		config_string_read();
		file_download();
		closed_channel_ignored();
		wait_passthrough();

		verdict_done = 1'b1;
		$display("** PASS **");
		$finish;
	end

	// run ended early, for instance by a failed assertion
	final begin
		if (!verdict_done) begin
			$display("** FAIL **");
		end
	end

endmodule

/* bench/hps_io_sva.sv */
`timescale 1ns/1ns
/*
 * bus and download pulse assertions
 * bound into the core frame logic and the file loader
 */
module hps_io_sva (
	input logic              clk_sys,
	input logic              rst,
	input logic              io_enable,
	input hps_pkg::io_word_t io_dout,
	input logic              cmd_stb,
	input logic              data_stb,
	input logic              ioctl_wr,
	input logic              ioctl_download
);

	// write pulse lasts a single cycle
	wr_single: assert property (@(posedge clk_sys) disable iff (rst) ioctl_wr |=> !ioctl_wr)
		else $error("ioctl_wr high on two consecutive cycles");

	wr_in_download: assert property (@(posedge clk_sys) disable iff (rst)
		ioctl_wr |-> ioctl_download)
		else $error("ioctl_wr outside a download");

	// word 0 is never data
	stb_exclusive: assert property (@(posedge clk_sys) disable iff (rst)
		!(cmd_stb && data_stb))
		else $error("cmd_stb and data_stb together");

	dout_idle: assert property (@(posedge clk_sys) disable iff (rst)
		!io_enable |=> (io_dout == '0))
		else $error("io_dout not zero outside a core frame");

endmodule

// frame side, no download signals here
bind hps_cmd_frame hps_io_sva i_hps_io_sva (
	.clk_sys        (clk_sys),
	.rst            (rst),
	.io_enable      (io_enable),
	.io_dout        (io_dout),
	.cmd_stb        (cmd_stb),
	.data_stb       (data_stb),
	.ioctl_wr       (1'b0),
	.ioctl_download (1'b0)
);

// loader side with the frame inputs held idle
bind file_loader hps_io_sva i_hps_io_sva (
	.clk_sys        (clk_sys),
	.rst            (rst),
	.io_enable      (1'b0),
	.io_dout        (16'h0000),
	.cmd_stb        (1'b0),
	.data_stb       (1'b0),
	.ioctl_wr       (ioctl_wr),
	.ioctl_download (ioctl_download)
);

/* src/hps_io_top.sv */
`timescale 1ns/1ns
/*
 * host I/O bridge top
 * command framing, register block, config ROM and file loader
 */
module hps_io_top (
	input  logic                  clk_sys,
	input  logic                  rst,
	input  logic                  io_strobe,
	input  logic                  io_enable,
	input  logic                  fp_enable,
	input  hps_pkg::io_word_t     io_din,
	input  hps_pkg::status_t      status_in,
	input  logic                  status_set,
	input  logic                  ioctl_wait,
	output hps_pkg::io_word_t     io_dout,
	output logic                  host_wait,
	output logic [1:0]            buttons,
	output logic                  forced_scandoubler,
	output logic                  direct_video,
	output hps_pkg::joy_t         joystick_0,
	output hps_pkg::joy_t         joystick_1,
	output hps_pkg::status_t      status,
	output logic                  ioctl_download,
	output hps_pkg::ioctl_index_t ioctl_index,
	output logic                  ioctl_wr,
	output hps_pkg::ioctl_addr_t  ioctl_addr,
	output hps_pkg::ioctl_data_t  ioctl_dout
);

	hps_pkg::cmd_t       cmd;
	hps_pkg::word_idx_t  word_idx;
	logic                cmd_stb;
	logic                data_stb;
	hps_pkg::io_word_t   regs_rdata;
	hps_pkg::conf_addr_t conf_addr;
	hps_pkg::conf_byte_t conf_byte;

	// core busy goes straight back to the host
	assign host_wait = ioctl_wait;

	////////////////////////////////////////////////////////////////////////////
	// core command channel
	////////////////////////////////////////////////////////////////////////////

	hps_cmd_frame i_hps_cmd_frame (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.io_strobe  (io_strobe),
		.io_enable  (io_enable),
		.io_din     (io_din),
		.regs_rdata (regs_rdata),
		.conf_byte  (conf_byte),
		.cmd        (cmd),
		.word_idx   (word_idx),
		.cmd_stb    (cmd_stb),
		.data_stb   (data_stb),
		.conf_addr  (conf_addr),
		.io_dout    (io_dout)
	);

	core_io_regs i_core_io_regs (
		.clk_sys            (clk_sys),
		.rst                (rst),
		.cmd                (cmd),
		.word_idx           (word_idx),
		.cmd_stb            (cmd_stb),
		.data_stb           (data_stb),
		.io_din             (io_din),
		.status_in          (status_in),
		.status_set         (status_set),
		.regs_rdata         (regs_rdata),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status)
	);

	conf_str_rom i_conf_str_rom (
		.clk_sys   (clk_sys),
		.conf_addr (conf_addr),
		.conf_byte (conf_byte)
	);

	////////////////////////////////////////////////////////////////////////////
	// file channel
	////////////////////////////////////////////////////////////////////////////

	file_loader i_file_loader (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.io_strobe      (io_strobe),
		.fp_enable      (fp_enable),
		.io_din         (io_din),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

endmodule

/* src/file_loader.sv */
`timescale 1ns/1ns
/*
 * file channel decoder
 * selects the file index, starts and stops downloads and streams
 * bytes to the core with an incrementing address
 */
module file_loader (
	input  logic                  clk_sys,
	input  logic                  rst,
	input  logic                  io_strobe,
	input  logic                  fp_enable,
	input  hps_pkg::io_word_t     io_din,
	output logic                  ioctl_download,
	output hps_pkg::ioctl_index_t ioctl_index,
	output logic                  ioctl_wr,
	output hps_pkg::ioctl_addr_t  ioctl_addr,
	output hps_pkg::ioctl_data_t  ioctl_dout
);

	hps_pkg::cmd_t        cmd;
	logic                 has_cmd;
	logic                 arg_seen;
	logic                 wr_pend;
	hps_pkg::ioctl_addr_t addr;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			has_cmd        <= 1'b0;
			arg_seen       <= 1'b0;
			wr_pend        <= 1'b0;
			ioctl_wr       <= 1'b0;
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_addr     <= '0;
			addr           <= '0;
		end else begin
			// write strobe trails the data word by two cycles
			ioctl_wr <= wr_pend;
			wr_pend  <= 1'b0;

			if (!fp_enable) begin
				has_cmd <= 1'b0;
			end else if (io_strobe) begin
				if (!has_cmd) begin
					cmd      <= io_din;
					has_cmd  <= 1'b1;
					arg_seen <= 1'b0;
				end else begin
					case (cmd)
						hps_pkg::FIO_FILE_INDEX: ioctl_index <= io_din;

						// first argument word starts or stops the download
						hps_pkg::FIO_FILE_TX: begin
							if (!arg_seen) begin
								arg_seen <= 1'b1;
								if (io_din[7:0] != 8'h00) begin
									addr           <= '0;
									ioctl_download <= 1'b1;
								end else begin
									// publish the byte count
									if (ioctl_download) begin
										ioctl_addr <= addr;
									end
									ioctl_download <= 1'b0;
								end
							end
						end

						hps_pkg::FIO_FILE_TX_DAT: begin
							if (ioctl_download) begin
								ioctl_addr <= addr;
								ioctl_dout <= io_din[7:0];
								wr_pend    <= 1'b1;
								addr       <= addr + 1'b1;
							end
						end

						default: ;
					endcase
				end
			end
		end
	end

endmodule

/* src/core_io_regs.sv */
`timescale 1ns/1ns
/*
 * core register block
 * config word, two joysticks, 64-bit status and the status request
 * capture, plus the read data for request frames
 */
module core_io_regs (
	input  logic               clk_sys,
	input  logic               rst,
	input  hps_pkg::cmd_t      cmd,
	input  hps_pkg::word_idx_t word_idx,
	input  logic               cmd_stb,
	input  logic               data_stb,
	input  hps_pkg::io_word_t  io_din,
	input  hps_pkg::status_t   status_in,
	input  logic               status_set,
	output hps_pkg::io_word_t  regs_rdata,
	output logic [1:0]         buttons,
	output logic               forced_scandoubler,
	output logic               direct_video,
	output hps_pkg::joy_t      joystick_0,
	output hps_pkg::joy_t      joystick_1,
	output hps_pkg::status_t   status
);

	hps_pkg::cfg_t    cfg;
	hps_pkg::status_t status_req;
	hps_pkg::stflg_t  stflg;
	logic             status_set_d;
	logic             status_edge;

	// word 1 fills the low half, word 2 the high half
	function automatic hps_pkg::joy_t joy_update(
		input hps_pkg::joy_t      cur,
		input hps_pkg::word_idx_t idx,
		input hps_pkg::io_word_t  din
	);
		hps_pkg::joy_t nxt;
		nxt = cur;
		if (idx == 6'd1) begin
			nxt[15:0] = din;
		end else if (idx == 6'd2) begin
			nxt[31:16] = din;
		end
		return nxt;
	endfunction

	// config bit map
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video       = cfg[10];

	////////////////////////////////////////////////////////////////////////////
	// host writes
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
		end else if (data_stb) begin
			case (cmd)
				hps_pkg::CMD_CFG: begin
					if (word_idx == 6'd1) begin
						cfg <= io_din;
					end
				end
				hps_pkg::CMD_JOY0: joystick_0 <= joy_update(joystick_0, word_idx, io_din);
				hps_pkg::CMD_JOY1: joystick_1 <= joy_update(joystick_1, word_idx, io_din);
				// 16-bit slices, low first
				hps_pkg::CMD_STATUS: begin
					case (word_idx)
						6'd1: status[15:0]  <= io_din;
						6'd2: status[31:16] <= io_din;
						6'd3: status[47:32] <= io_din;
						6'd4: status[63:48] <= io_din;
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// status request from the core
	////////////////////////////////////////////////////////////////////////////

	assign status_edge = status_set && !status_set_d;

	// only rising edges count, a held level does nothing
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			status_set_d <= 1'b0;
			stflg        <= '0;
			status_req   <= '0;
		end else begin
			status_set_d <= status_set;
			if (status_edge) begin
				stflg      <= stflg + 1'b1;
				status_req <= status_in;
			end
		end
	end

	// read data, zero for anything not owned here
	always_comb begin
		regs_rdata = '0;
		if (cmd_stb && (io_din == hps_pkg::CMD_STATUS_REQ)) begin
			regs_rdata = {8'h00, hps_pkg::STATUS_REQ_TAG, stflg};
		end else if (data_stb && (cmd == hps_pkg::CMD_STATUS_REQ)) begin
			case (word_idx)
				6'd1: regs_rdata = status_req[15:0];
				6'd2: regs_rdata = status_req[31:16];
				6'd3: regs_rdata = status_req[47:32];
				6'd4: regs_rdata = status_req[63:48];
				default: regs_rdata = '0;
			endcase
		end
	end

endmodule

/* src/hps_cmd_frame.sv */
`timescale 1ns/1ns
/*
 * core command framing
 * latches the command word, counts frame words, serves config string
 * reads from the ROM and registers the reply word for the host
 */
module hps_cmd_frame (
	input  logic                clk_sys,
	input  logic                rst,
	input  logic                io_strobe,
	input  logic                io_enable,
	input  hps_pkg::io_word_t   io_din,
	input  hps_pkg::io_word_t   regs_rdata,
	input  hps_pkg::conf_byte_t conf_byte,
	output hps_pkg::cmd_t       cmd,
	output hps_pkg::word_idx_t  word_idx,
	output logic                cmd_stb,
	output logic                data_stb,
	output hps_pkg::conf_addr_t conf_addr,
	output hps_pkg::io_word_t   io_dout
);

	logic              conf_hit;
	logic              conf_pend;
	hps_pkg::io_word_t reply_base;
	hps_pkg::io_word_t conf_word;

	// word 0 carries the command, everything after is data
	assign cmd_stb  = io_enable && io_strobe && (word_idx == '0);
	assign data_stb = io_enable && io_strobe && (word_idx != '0);

	////////////////////////////////////////////////////////////////////////////
	// frame state
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst || !io_enable) begin
			cmd      <= '0;
			word_idx <= '0;
		end else if (io_strobe) begin
			if (cmd_stb) begin
				cmd <= io_din;
			end
			// hold at 63 on long frames
			if (word_idx != '1) begin
				word_idx <= word_idx + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// config string read
	////////////////////////////////////////////////////////////////////////////

	// data word k fetches string byte k-1
	assign conf_addr = (word_idx == '0) ? '0 : hps_pkg::conf_addr_t'(word_idx - 1'b1);

	assign conf_hit = data_stb && (cmd == hps_pkg::CMD_CONF_STR) &&
		(word_idx <= hps_pkg::CONF_LEN);

	// ROM byte arrives one cycle after the strobe
	assign conf_word = conf_pend ? {8'h00, conf_byte} : '0;

	////////////////////////////////////////////////////////////////////////////
	// reply register
	////////////////////////////////////////////////////////////////////////////

	// a strobe loads the register block reply, the ROM byte is merged a cycle later
	assign reply_base = io_strobe ? regs_rdata : io_dout;

	always_ff @(posedge clk_sys) begin
		if (rst || !io_enable) begin
			conf_pend <= 1'b0;
			io_dout   <= '0;
		end else begin
			conf_pend <= conf_hit;
			io_dout   <= reply_base | conf_word;
		end
	end

endmodule

/* src/conf_str_rom.sv */
`timescale 1ns/1ns
/*
 * config string ROM
 * byte array built from the package string, one-cycle registered read
 */
module conf_str_rom (
	input  logic                clk_sys,
	input  hps_pkg::conf_addr_t conf_addr,
	output hps_pkg::conf_byte_t conf_byte
);

	hps_pkg::conf_byte_t rom [hps_pkg::CONF_LEN];

	// string is packed with the first character at the top
	initial begin
		for (int i = 0; i < hps_pkg::CONF_LEN; i++) begin
			rom[i] = hps_pkg::CONF_STR[(hps_pkg::CONF_LEN - 1 - i) * 8 +: 8];
		end
	end

	// addresses past the end read as zero
	always_ff @(posedge clk_sys) begin
		if (conf_addr < hps_pkg::CONF_LEN) begin
			conf_byte <= rom[conf_addr];
		end else begin
			conf_byte <= '0;
		end
	end

endmodule

/* src/hps_pkg.sv */
/*
 * shared definitions for the host I/O bridge
 * word types, command codes and the configuration string
 */
package hps_pkg;

	////////////////////////////////////////////////////////////////////////////
	// word and field types
	////////////////////////////////////////////////////////////////////////////

	// one host bus word
	typedef logic [15:0] io_word_t;
	typedef logic [15:0] cmd_t;

	// position of a word inside a frame, saturates at 63
	typedef logic [5:0] word_idx_t;

	typedef logic [31:0] joy_t;
	typedef logic [63:0] status_t;
	typedef logic [15:0] cfg_t;

	// config string ROM
	typedef logic [7:0] conf_byte_t;
	typedef logic [5:0] conf_addr_t;

	// download side
	typedef logic [26:0] ioctl_addr_t;
	typedef logic [7:0]  ioctl_data_t;
	typedef logic [15:0] ioctl_index_t;

	// status request counter
	typedef logic [3:0] stflg_t;

	////////////////////////////////////////////////////////////////////////////
	// command codes
	////////////////////////////////////////////////////////////////////////////

	// core channel, io_enable frames
	localparam cmd_t CMD_CFG        = 16'h0001;
	localparam cmd_t CMD_JOY0       = 16'h0002;
	localparam cmd_t CMD_JOY1       = 16'h0003;
	localparam cmd_t CMD_CONF_STR   = 16'h0014;
	localparam cmd_t CMD_STATUS     = 16'h001E;
	localparam cmd_t CMD_STATUS_REQ = 16'h0029;

	// file channel, fp_enable frames
	localparam cmd_t FIO_FILE_TX     = 16'h0053;
	localparam cmd_t FIO_FILE_TX_DAT = 16'h0054;
	localparam cmd_t FIO_FILE_INDEX  = 16'h0055;

	// upper nibble of the request reply, counter sits below it
	localparam logic [3:0] STATUS_REQ_TAG = 4'hA;

	////////////////////////////////////////////////////////////////////////////
	// configuration string
	////////////////////////////////////////////////////////////////////////////

	// length in bytes, must stay at or below 62
	localparam int CONF_LEN = 40;

	// first character in the top byte
	localparam logic [CONF_LEN*8-1:0] CONF_STR =
		"DEMO;;O1,Aspect,4:3,16:9;R0,Reset;V,v1.0";

endpackage
